//--- src/hist_data_pkg.sv
package hist_data_pkg;

    // arrival code from the TDC
    localparam int CODE_BITS  = 6;

    // histogram geometry
    localparam int BIN_BITS   = 4;
    localparam int NUM_BINS   = 16;
    localparam int PIX_BITS   = 2;
    localparam int NUM_PIXELS = 4;

    // saturating counter range
    localparam int COUNT_BITS = 8;
    localparam int COUNT_MAX  = 255;

    // one entry per pixel and bin
    localparam int MEM_DEPTH  = NUM_PIXELS * NUM_BINS;

    typedef logic [CODE_BITS-1:0]           code_t;
    typedef logic [BIN_BITS-1:0]            bin_t;
    typedef logic [PIX_BITS-1:0]            pixel_t;
    typedef logic [COUNT_BITS-1:0]          count_t;

    // flat address, pixel in the upper bits
    typedef logic [PIX_BITS+BIN_BITS-1:0]   mem_addr_t;

endpackage

//--- src/hist_ctrl_pkg.sv
package hist_ctrl_pkg;

    typedef logic [1:0] cfg_addr_t;

    // register map
    localparam cfg_addr_t REG_MODE      = 2'd0;  // bit 0 selects fine mode
    localparam cfg_addr_t REG_FINE_BASE = 2'd1;  // window base code
    localparam cfg_addr_t REG_HITS      = 2'd2;  // hits per pixel
    localparam cfg_addr_t REG_ACQS      = 2'd3;  // acquisitions per frame

    typedef enum logic {COARSE = 1'b0, FINE = 1'b1} hist_mode_e;

    typedef enum logic {ACCUM, WAIT_SCAN} seq_state_e;
    typedef enum logic [1:0] {IDLE, SCAN, REPORT, DONE} scan_state_e;
    typedef enum logic {RUN, CLEAR} mem_state_e;

    // values after reset
    localparam hist_mode_e           RST_MODE      = COARSE;
    localparam hist_data_pkg::code_t RST_FINE_BASE = '0;
    localparam logic [7:0]           RST_HITS      = 8'd4;
    localparam logic [7:0]           RST_ACQS      = 8'd2;

endpackage

//--- src/hist_if.sv
`timescale 1ns/100ps

interface hist_cfg_if;
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    hist_mode_e mode;
    code_t      fine_base;
    logic [7:0] hits_per_pixel;  // never zero
    logic [7:0] acqs_per_frame;  // never zero

    modport regs (output mode, fine_base, hits_per_pixel, acqs_per_frame);
    modport seq  (input  mode, fine_base, hits_per_pixel, acqs_per_frame);
endinterface

interface bin_upd_if;
    import hist_data_pkg::*;

    logic   valid;
    logic   ready;
    pixel_t pixel;
    bin_t   bin;

    modport src  (output valid, pixel, bin, input  ready);
    modport sink (input  valid, pixel, bin, output ready);
endinterface

interface bin_rd_if;
    import hist_data_pkg::*;

    logic   req;
    pixel_t pixel;
    bin_t   bin;
    count_t data;        // one cycle after req
    logic   data_valid;

    modport scan (output req, pixel, bin, input  data, data_valid);
    modport mem  (input  req, pixel, bin, output data, data_valid);
endinterface

//--- src/hist_config_regs.sv
`timescale 1ns/100ps

module hist_config_regs (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     cfg_we,
    input  hist_ctrl_pkg::cfg_addr_t cfg_addr,
    input  logic [7:0]               cfg_wdata,
    hist_cfg_if.regs                 cfg
);
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    hist_mode_e mode_q;
    code_t      base_q;
    logic [7:0] hits_q;
    logic [7:0] acqs_q;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            mode_q <= RST_MODE;
            base_q <= RST_FINE_BASE;
            hits_q <= RST_HITS;
            acqs_q <= RST_ACQS;
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_MODE:      mode_q <= hist_mode_e'(cfg_wdata[0]);
                REG_FINE_BASE: base_q <= cfg_wdata[CODE_BITS-1:0];
                REG_HITS:      hits_q <= (cfg_wdata == 8'd0) ? 8'd1 : cfg_wdata;  // 0 -> 1
                REG_ACQS:      acqs_q <= (cfg_wdata == 8'd0) ? 8'd1 : cfg_wdata;
                default:       ;
            endcase
        end
    end

    assign cfg.mode           = mode_q;
    assign cfg.fine_base      = base_q;
    assign cfg.hits_per_pixel = hits_q;
    assign cfg.acqs_per_frame = acqs_q;

endmodule

//--- src/acq_sequencer.sv
`timescale 1ns/100ps

module acq_sequencer (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 hit_valid,
    output logic                 hit_ready,
    input  hist_data_pkg::code_t hit_code,
    hist_cfg_if.seq              cfg,
    bin_upd_if.src               upd,
    output logic                 frame_done,
    input  logic                 scan_done
);
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    seq_state_e         state;
    logic               frame_start;  // no hit taken yet this frame
    hist_mode_e         mode_l;
    code_t              base_l;
    logic [7:0]         hits_l;
    logic [7:0]         acqs_l;
    hist_mode_e         mode_cur;
    code_t              base_cur;
    logic [7:0]         hits_cur;
    logic [7:0]         acqs_cur;
    logic [7:0]         hit_cnt;
    pixel_t             pix_cnt;
    logic [7:0]         acq_cnt;
    logic [CODE_BITS:0] diff;         // extra bit flags code below base
    logic               in_win;
    logic               hit_fire;
    logic               last_hit;
    logic               last_pix;
    logic               last_acq;

    // live config until the first hit of a frame locks it
    assign mode_cur = frame_start ? cfg.mode : mode_l;
    assign base_cur = frame_start ? cfg.fine_base : base_l;
    assign hits_cur = frame_start ? cfg.hits_per_pixel : hits_l;
    assign acqs_cur = frame_start ? cfg.acqs_per_frame : acqs_l;

    assign diff    = {1'b0, hit_code} - {1'b0, base_cur};
    assign in_win  = (mode_cur == COARSE) || (diff[CODE_BITS:BIN_BITS] == '0);

    assign hit_ready = (state == ACCUM) && upd.ready;
    assign hit_fire  = hit_valid && hit_ready;
    assign upd.valid = (state == ACCUM) && hit_valid && in_win;
    assign upd.pixel = pix_cnt;
    assign upd.bin   = (mode_cur == COARSE) ? hit_code[CODE_BITS-1 -: BIN_BITS]
                                            : diff[BIN_BITS-1:0];

    assign last_hit = (hit_cnt == hits_cur - 8'd1);
    assign last_pix = (pix_cnt == pixel_t'(NUM_PIXELS - 1));
    assign last_acq = (acq_cnt == acqs_cur - 8'd1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state       <= ACCUM;
            frame_start <= 1'b1;
            hit_cnt     <= '0;
            pix_cnt     <= '0;
            acq_cnt     <= '0;
            frame_done  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (hit_fire) begin
                frame_start <= 1'b0;
                if (!last_hit) begin
                    hit_cnt <= hit_cnt + 8'd1;
                end else begin
                    hit_cnt <= '0;
                    pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                    if (last_pix && last_acq) begin  // frame complete
                        acq_cnt     <= '0;
                        frame_done  <= 1'b1;
                        frame_start <= 1'b1;
                        state       <= WAIT_SCAN;
                    end else if (last_pix) begin
                        acq_cnt <= acq_cnt + 8'd1;
                    end
                end
            end
            if ((state == WAIT_SCAN) && scan_done) begin
                state <= ACCUM;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_fire && frame_start) begin  // freeze config for the frame
            mode_l <= cfg.mode;
            base_l <= cfg.fine_base;
            hits_l <= cfg.hits_per_pixel;
            acqs_l <= cfg.acqs_per_frame;
        end
    end

endmodule

//--- src/bin_memory.sv
`timescale 1ns/100ps

module bin_memory (
    input  logic   clk,
    input  logic   combin_res,
    bin_upd_if.sink upd,
    bin_rd_if.mem   rd,
    input  logic   scan_done
);
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    count_t     mem [MEM_DEPTH];
    mem_state_e state;
    mem_addr_t  clr_addr;
    mem_addr_t  upd_addr;
    count_t     rd_data_q;
    logic       rd_valid_q;

    assign upd.ready = (state == RUN);
    assign upd_addr  = {upd.pixel, upd.bin};

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= RUN;
            clr_addr <= '0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (state == CLEAR) begin
            mem[clr_addr] <= '0;        // one entry per cycle
            clr_addr      <= clr_addr + 1'b1;
            if (clr_addr == mem_addr_t'(MEM_DEPTH - 1)) begin
                state <= RUN;
            end
        end else begin
            if (upd.valid) begin
                if (mem[upd_addr] != count_t'(COUNT_MAX)) begin  // saturate
                    mem[upd_addr] <= mem[upd_addr] + 1'b1;
                end
            end
            if (scan_done) begin
                state    <= CLEAR;
                clr_addr <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd.req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.req) begin
            rd_data_q <= mem[{rd.pixel, rd.bin}];
        end
    end

    assign rd.data       = rd_data_q;
    assign rd.data_valid = rd_valid_q;

endmodule

//--- src/peak_finder.sv
`timescale 1ns/100ps

module peak_finder (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  frame_done,
    bin_rd_if.scan                rd,
    output logic                  scan_done,
    output logic                  peak_valid,
    input  logic                  peak_ready,
    output hist_data_pkg::pixel_t peak_pixel,
    output hist_data_pkg::bin_t   peak_bin,
    output hist_data_pkg::count_t peak_count
);
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    scan_state_e state;
    pixel_t      pix_q;
    bin_t        req_bin;     // next bin to read
    logic        req_done;    // all 16 reads issued
    bin_t        rcv_bin;     // bin of returning data
    count_t      max_q;
    bin_t        max_bin;

    assign rd.req    = (state == SCAN) && !req_done;
    assign rd.pixel  = pix_q;
    assign rd.bin    = req_bin;

    assign peak_valid = (state == REPORT);
    assign peak_pixel = pix_q;
    assign peak_bin   = max_bin;
    assign peak_count = max_q;
    assign scan_done  = (state == DONE);  // lasts one cycle

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= IDLE;
            pix_q    <= '0;
            req_bin  <= '0;
            req_done <= 1'b0;
            rcv_bin  <= '0;
            max_q    <= '0;
            max_bin  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_done) begin
                        state    <= SCAN;
                        pix_q    <= '0;
                        req_bin  <= '0;
                        req_done <= 1'b0;
                        rcv_bin  <= '0;
                        max_q    <= '0;
                        max_bin  <= '0;
                    end
                end
                SCAN: begin
                    if (rd.req) begin
                        req_bin  <= req_bin + 1'b1;
                        req_done <= (req_bin == bin_t'(NUM_BINS - 1));
                    end
                    if (rd.data_valid) begin
                        rcv_bin <= rcv_bin + 1'b1;
                        if (rd.data > max_q) begin  // strict, lowest bin keeps ties
                            max_q   <= rd.data;
                            max_bin <= rcv_bin;
                        end
                        if (rcv_bin == bin_t'(NUM_BINS - 1)) begin
                            state <= REPORT;
                        end
                    end
                end
                REPORT: begin
                    if (peak_ready) begin
                        if (pix_q == pixel_t'(NUM_PIXELS - 1)) begin
                            state <= DONE;
                        end else begin
                            state    <= SCAN;
                            pix_q    <= pix_q + 1'b1;
                            req_bin  <= '0;
                            req_done <= 1'b0;
                            rcv_bin  <= '0;
                            max_q    <= '0;
                            max_bin  <= '0;
                        end
                    end
                end
                default: state <= IDLE;  // DONE
            endcase
        end
    end

endmodule

//--- src/histogram_top.sv
`timescale 1ns/100ps

module histogram_top (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     hit_valid,
    output logic                     hit_ready,
    input  hist_data_pkg::code_t     hit_code,
    input  logic                     cfg_we,
    input  hist_ctrl_pkg::cfg_addr_t cfg_addr,
    input  logic [7:0]               cfg_wdata,
    output logic                     peak_valid,
    input  logic                     peak_ready,
    output hist_data_pkg::pixel_t    peak_pixel,
    output hist_data_pkg::bin_t      peak_bin,
    output hist_data_pkg::count_t    peak_count
);

    logic frame_done;  // sequencer -> peak finder
    logic scan_done;   // peak finder -> memory, sequencer

    hist_cfg_if cfg_bus ();
    bin_upd_if  upd_bus ();
    bin_rd_if   rd_bus ();

    hist_config_regs u_cfg (
        .clk(clk), .combin_res(combin_res),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg(cfg_bus.regs)
    );

    acq_sequencer u_seq (
        .clk(clk), .combin_res(combin_res),
        .hit_valid(hit_valid), .hit_ready(hit_ready), .hit_code(hit_code),
        .cfg(cfg_bus.seq), .upd(upd_bus.src),
        .frame_done(frame_done), .scan_done(scan_done)
    );

    bin_memory u_mem (
        .clk(clk), .combin_res(combin_res),
        .upd(upd_bus.sink), .rd(rd_bus.mem), .scan_done(scan_done)
    );

    peak_finder u_peak (
        .clk(clk), .combin_res(combin_res),
        .frame_done(frame_done), .rd(rd_bus.scan), .scan_done(scan_done),
        .peak_valid(peak_valid), .peak_ready(peak_ready),
        .peak_pixel(peak_pixel), .peak_bin(peak_bin), .peak_count(peak_count)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic combin_res
);
    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        combin_res = 1'b0;
        repeat (10) @(posedge clk);
        #1 combin_res = 1'b1;  // release just after an edge
    end

endmodule

//--- testbench/tb_histogram.sv
`timescale 1ns/100ps

module tb_histogram;
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    // hit totals of reset, fine, back-pressure, saturation and ties, clear
    localparam int TOTAL_HITS   = 32 + 48 + 32 + 1200 + 32 + 64;
    localparam int NUM_FRAMES   = 7;
    localparam int FRAME_CYCLES = NUM_PIXELS * (NUM_BINS + 3 + 8) + MEM_DEPTH + 10;
    localparam int LIMIT_CYCLES = 2 * TOTAL_HITS + NUM_FRAMES * FRAME_CYCLES + 200;

    logic      clk;
    logic      combin_res;
    logic      hit_valid;
    logic      hit_ready;
    code_t     hit_code;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    logic [7:0] cfg_wdata;
    logic      peak_valid;
    logic      peak_ready;
    pixel_t    peak_pixel;
    bin_t      peak_bin;
    count_t    peak_count;

    logic [31:0] rng_state = 32'h8389_6f04;
    int          n_checks;
    int          n_errors;
    int          n_tests;

    // reference model of the frame being built
    hist_mode_e f_mode;
    code_t      f_base;
    int         f_hits;
    int         f_acqs;
    int         model_cnt [NUM_PIXELS][NUM_BINS];
    code_t      hit_q[$];
    int         exp_pix[$];
    int         exp_bin[$];
    int         exp_cnt[$];

    tb_clock_gen clk_gen (.clk(clk), .combin_res(combin_res));

    histogram_top dut0 (
        .clk(clk), .combin_res(combin_res),
        .hit_valid(hit_valid), .hit_ready(hit_ready), .hit_code(hit_code),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .peak_valid(peak_valid), .peak_ready(peak_ready),
        .peak_pixel(peak_pixel), .peak_bin(peak_bin), .peak_count(peak_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % n);
    endfunction

    task automatic compare_values(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        $display("test %0s finished, %0d new errors", name, n_errors - errs_before);
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic begin_frame(input hist_mode_e mode, input code_t base,
                               input int hits, input int acqs);
        f_mode = mode;
        f_base = base;
        f_hits = hits;
        f_acqs = acqs;
        for (int p = 0; p < NUM_PIXELS; p++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                model_cnt[p][b] = 0;
            end
        end
    endtask

    function automatic int frame_len();
        return f_hits * NUM_PIXELS * f_acqs;
    endfunction

    function automatic int pixel_of(input int i);
        return (i / f_hits) % NUM_PIXELS;  // pixel by pixel within each acquisition
    endfunction

    task automatic queue_hit(input int i, input code_t code);
        int pix;
        int bin;
        pix = pixel_of(i);
        hit_q.push_back(code);
        if (f_mode == COARSE) begin
            bin = int'(code) / 4;  // upper four bits
        end else begin
            bin = int'(code) - int'(f_base);
        end
        if (bin >= 0 && bin < NUM_BINS && model_cnt[pix][bin] < COUNT_MAX) begin
            model_cnt[pix][bin]++;
        end
    endtask

    task automatic close_frame();
        int best_b;
        for (int p = 0; p < NUM_PIXELS; p++) begin
            best_b = 0;
            for (int b = 1; b < NUM_BINS; b++) begin
                if (model_cnt[p][b] > model_cnt[p][best_b]) begin
                    best_b = b;  // strict compare keeps the lower bin on ties
                end
            end
            exp_pix.push_back(p);
            exp_bin.push_back(best_b);
            exp_cnt.push_back(model_cnt[p][best_b]);
        end
    endtask

    task automatic send_hits(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            hit_valid = 1'b1;
            hit_code  = hit_q.pop_front();
            @(negedge clk);
            while (!hit_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        hit_valid = 1'b0;
    endtask

    task automatic collect_peaks(input bit backpressure);
        int     e_pix;
        int     e_bin;
        int     e_cnt;
        int     hold;
        bit     held;
        bit     got;
        pixel_t h_pix;
        bin_t   h_bin;
        count_t h_cnt;
        for (int k = 0; k < NUM_PIXELS; k++) begin
            e_pix = exp_pix.pop_front();
            e_bin = exp_bin.pop_front();
            e_cnt = exp_cnt.pop_front();
            hold  = backpressure ? rand_below(8) : 0;
            held  = 1'b0;
            got   = 1'b0;
            while (!got) begin
                @(posedge clk);
                #1;
                peak_ready = (hold == 0);
                @(negedge clk);
                if (held) begin  // peak must not move while stalled
                    compare_values("peak_valid", peak_valid, 1);
                    compare_values("peak_pixel", peak_pixel, h_pix);
                    compare_values("peak_bin", peak_bin, h_bin);
                    compare_values("peak_count", peak_count, h_cnt);
                end
                if (peak_valid) begin
                    compare_values("hit_ready", hit_ready, 0);
                    if (peak_ready) begin
                        compare_values("peak_pixel", peak_pixel, e_pix);
                        compare_values("peak_bin", peak_bin, e_bin);
                        compare_values("peak_count", peak_count, e_cnt);
                        got = 1'b1;
                    end else begin
                        held  = 1'b1;
                        h_pix = peak_pixel;
                        h_bin = peak_bin;
                        h_cnt = peak_count;
                        hold--;
                    end
                end
            end
        end
        @(posedge clk);
        #1;
        peak_ready = 1'b0;
    endtask

    task automatic run_frame(input bit backpressure);
        int n;
        n = hit_q.size();
        fork
            send_hits(n);
            collect_peaks(backpressure);
        join
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = n_errors;
        @(negedge clk);
        compare_values("hit_ready", hit_ready, 1);
        compare_values("peak_valid", peak_valid, 0);
        begin_frame(COARSE, '0, 4, 2);
        for (int i = 0; i < frame_len(); i++) begin
            queue_hit(i, code_t'(rand_below(64)));
        end
        close_frame();
        run_frame(1'b0);
        report_test("reset_state", e0);
    endtask

    task automatic test_fine_mode();
        int e0;
        e0 = n_errors;
        write_cfg(REG_MODE, 8'd1);
        write_cfg(REG_FINE_BASE, 8'd20);
        write_cfg(REG_HITS, 8'd6);
        begin_frame(FINE, code_t'(20), 6, 2);
        for (int i = 0; i < frame_len(); i++) begin
            if (rand_below(2) == 1) begin
                queue_hit(i, code_t'(20 + rand_below(16)));  // inside the window
            end else begin
                queue_hit(i, code_t'(rand_below(64)));
            end
        end
        close_frame();
        run_frame(1'b0);
        report_test("fine_mode", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = n_errors;
        write_cfg(REG_MODE, 8'd0);
        write_cfg(REG_HITS, 8'd4);
        begin_frame(COARSE, '0, 4, 2);
        for (int i = 0; i < frame_len(); i++) begin
            queue_hit(i, code_t'(rand_below(64)));
        end
        close_frame();
        run_frame(1'b1);
        report_test("backpressure", e0);
    endtask

    task automatic test_saturation_ties();
        int e0;
        int bin;
        e0 = n_errors;
        write_cfg(REG_HITS, 8'd100);
        write_cfg(REG_ACQS, 8'd3);  // 300 hits per pixel
        begin_frame(COARSE, '0, 100, 3);
        for (int i = 0; i < frame_len(); i++) begin
            bin = (pixel_of(i) * 5 + 3) % NUM_BINS;
            queue_hit(i, code_t'(bin * 4 + rand_below(4)));
        end
        close_frame();
        run_frame(1'b0);
        write_cfg(REG_HITS, 8'd8);
        write_cfg(REG_ACQS, 8'd1);
        begin_frame(COARSE, '0, 8, 1);
        for (int i = 0; i < frame_len(); i++) begin
            // equal counts in two bins with the upper one hit first
            bin = (i % 2 == 0) ? pixel_of(i) + 9 : pixel_of(i) + 2;
            queue_hit(i, code_t'(bin * 4 + rand_below(4)));
        end
        close_frame();
        run_frame(1'b0);
        report_test("saturation_ties", e0);
    endtask

    task automatic test_clear();
        int e0;
        int n_a;
        int n_b;
        int clear_low;
        e0 = n_errors;
        clear_low = 0;
        write_cfg(REG_HITS, 8'd4);
        write_cfg(REG_ACQS, 8'd2);
        begin_frame(COARSE, '0, 4, 2);
        for (int i = 0; i < frame_len(); i++) begin
            queue_hit(i, code_t'(rand_below(32)));  // bins 0..7
        end
        close_frame();
        n_a = frame_len();
        begin_frame(COARSE, '0, 4, 2);
        for (int i = 0; i < frame_len(); i++) begin
            queue_hit(i, code_t'(32 + rand_below(32)));  // bins 8..15
        end
        close_frame();
        n_b = frame_len();
        fork
            begin
                send_hits(n_a);
                send_hits(n_b);  // offered during scan and clear
            end
            begin
                collect_peaks(1'b0);
                @(negedge clk);
                while (!hit_ready) begin  // cycles after the last peak
                    clear_low++;
                    @(negedge clk);
                end
                collect_peaks(1'b0);
            end
        join
        compare_values("hit_ready low cycles >= MEM_DEPTH", clear_low >= MEM_DEPTH, 1);
        report_test("clear", e0);
    endtask

    initial begin
        hit_valid  = 1'b0;
        hit_code   = '0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        peak_ready = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        n_tests    = 0;
        @(posedge combin_res);
        @(posedge clk);
        test_reset_state();
        test_fine_mode();
        test_backpressure();
        test_saturation_ties();
        test_clear();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 10);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- build.f
src/hist_data_pkg.sv
src/hist_ctrl_pkg.sv
src/hist_if.sv
src/hist_config_regs.sv
src/acq_sequencer.sv
src/bin_memory.sv
src/peak_finder.sv
src/histogram_top.sv
testbench/tb_clock_gen.sv
testbench/tb_histogram.sv

//--- Bender.yml
package:
  name: histogram

sources:
  - src/hist_data_pkg.sv
  - src/hist_ctrl_pkg.sv
  - src/hist_if.sv
  - src/hist_config_regs.sv
  - src/acq_sequencer.sv
  - src/bin_memory.sv
  - src/peak_finder.sv
  - src/histogram_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_histogram.sv
